// File: filelist.f
cpuPkg.sv
memBusIf.sv
hazardUnit.sv
fetchUnit.sv
pipeCore.sv
memArbiter.sv
unifiedMem.sv
cpuTop.sv
tbCpu.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - cpuPkg.sv
  - memBusIf.sv
  - hazardUnit.sv
  - fetchUnit.sv
  - pipeCore.sv
  - memArbiter.sv
  - unifiedMem.sv
  - cpuTop.sv
  - target: test
    files:
      - tbCpu.sv

// File: tbCpu.sv
`timescale 1ns/100ps

module tbCpu import cpuPkg::*; ();

    localparam int MemWords   = 256;
    localparam int RunTimeout = 2000;   // Cycles allowed from runEn to halt
    localparam int ModelSteps = 1000;

    logic    clk;
    logic    arstN;
    logic    runEn;
    logic    loadEn;
    addr_t   loadAddr;
    word_t   loadData;
    logic    retireValid;
    regIdx_t retireRd;
    word_t   retireData;
    logic    halted;

    word_t   prog [$];
    word_t   image [MemWords];   // Full memory image of the current test
    regIdx_t expRd [$];
    word_t   expData [$];
    int      expIdx;
    int      mismatchCount;
    int      failCount;
    int      seed;

    cpuTop #(.AddrWidth(8)) u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .runEn       (runEn),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction encoders
    function automatic word_t encImm(opcode_e op, regIdx_t rs, regIdx_t rt, int imm);
        return {op, rs, rt, imm[4:0]};
    endfunction

    function automatic word_t encAdd(regIdx_t rd, regIdx_t rs, regIdx_t rt);
        return {OP_ADD, rs, rt, rd, 2'b00};
    endfunction

    function automatic word_t encJump(opcode_e op, int off);
        return {op, off[10:0]};
    endfunction

    function automatic word_t encBeqz(regIdx_t rs, int off);
        return {OP_BEQZ, rs, off[7:0]};
    endfunction

    task automatic checkReg(input string name, input regIdx_t got, input regIdx_t exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        arstN  <= 1'b0;
        runEn  <= 1'b0;
        loadEn <= 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
    endtask

    // Writes every word so no test sees leftovers of the one before
    task automatic loadProgram();
        for (int a = 0; a < MemWords; a++) begin
            if (a < prog.size()) begin
                image[a] = prog[a];
            end else begin
                image[a] = {a[7:0], ~a[7:0]};   // Fill differs at every address
            end
        end
        for (int a = 0; a < MemWords; a++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= addr_t'(a);
            loadData <= image[a];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        @(negedge clk);
        checkFlag("retireValid", retireValid, 1'b0);   // Core still idle
        checkFlag("halted", halted, 1'b0);
    endtask

    // ISA reference, one instruction per step
    task automatic predictRetires();
        word_t   mdlMem [MemWords];
        word_t   regs [8];
        addr_t   pc;
        word_t   w;
        word_t   ea;
        word_t   nextPc;
        regIdx_t wrIdx;
        word_t   wrVal;
        logic    wrEn;
        logic    done;
        int      steps;
        mdlMem = image;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        expRd.delete();
        expData.delete();
        expIdx = 0;
        pc     = '0;
        done   = 1'b0;
        steps  = 0;
        while (!done && steps < ModelSteps) begin
            w      = mdlMem[pc];
            nextPc = {8'h00, pc} + 16'd1;
            ea     = regs[w[10:8]] + {{11{w[4]}}, w[4:0]};
            wrEn   = 1'b0;
            wrIdx  = w[7:5];
            wrVal  = ea;
            steps++;
            if (w[15:13] == 3'b011) begin
                if (regs[w[10:8]] == '0) begin
                    nextPc = nextPc + {{8{w[7]}}, w[7:0]};
                end
            end else begin
                case (w[15:11])
                    OP_HALT: done = 1'b1;
                    OP_J:    nextPc = nextPc + {{5{w[10]}}, w[10:0]};
                    OP_JAL: begin
                        wrEn   = 1'b1;
                        wrIdx  = LINK_REG;
                        wrVal  = nextPc;   // Return address
                        nextPc = nextPc + {{5{w[10]}}, w[10:0]};
                    end
                    OP_ADDI: wrEn = 1'b1;
                    OP_ST:   mdlMem[ea[7:0]] = regs[w[7:5]];
                    OP_LD: begin
                        wrEn  = 1'b1;
                        wrVal = mdlMem[ea[7:0]];
                    end
                    OP_ADD: begin
                        wrEn  = 1'b1;
                        wrIdx = w[4:2];
                        wrVal = regs[w[10:8]] + regs[w[7:5]];
                    end
                    default: ;
                endcase
            end
            if (wrEn) begin
                regs[wrIdx] = wrVal;
                expRd.push_back(wrIdx);
                expData.push_back(wrVal);
            end
            pc = nextPc[7:0];
        end
        if (!done) begin
            failCount++;
            $display("Reference model never reached HALT");
        end
    endtask

    task automatic compareRetire(input string name);
        if (expIdx >= expRd.size()) begin
            failCount++;
            $display("%s: unexpected retire to r%0d", name, retireRd);
        end else begin
            checkReg("retireRd", retireRd, expRd[expIdx]);
            checkWord("retireData", retireData, expData[expIdx]);
            expIdx++;
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        runEn <= 1'b1;
        while (!halted && cycles < RunTimeout) begin
            @(negedge clk);
            if (retireValid) begin
                compareRetire(name);
            end
            cycles++;
        end
        if (!halted) begin
            failCount++;
            $display("%s: core did not halt within %0d cycles", name, RunTimeout);
        end
        repeat (4) begin
            @(negedge clk);
            if (retireValid) begin
                failCount++;
                $display("%s: register write retired after halt", name);
            end
        end
        if (expIdx < expRd.size()) begin
            failCount++;
            $display("%s: %0d of %0d expected retires never arrived", name,
                expRd.size() - expIdx, expRd.size());
        end
        @(posedge clk);
        runEn <= 1'b0;
    endtask

    task automatic runTest(input string name);
        resetDut();
        loadProgram();
        predictRetires();
        runProgram(name);
    endtask

    // Every instruction reads the result just before it
    task automatic testAluChain();
        prog.delete();
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd1, 5));
        prog.push_back(encImm(OP_ADDI, 3'd1, 3'd2, -3));
        prog.push_back(encAdd(3'd3, 3'd1, 3'd2));
        prog.push_back(encAdd(3'd4, 3'd3, 3'd3));
        prog.push_back(encImm(OP_ADDI, 3'd4, 3'd4, 7));
        prog.push_back(encAdd(3'd5, 3'd4, 3'd1));
        prog.push_back(encImm(OP_ADDI, 3'd5, 3'd6, -16));
        prog.push_back(encJump(OP_HALT, 0));
        runTest("aluChain");
    endtask

    task automatic testStoreLoad();
        prog.delete();
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd1, -16));   // Base 0xfff0
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd2, 9));
        prog.push_back(encImm(OP_ST, 3'd1, 3'd2, 3));
        prog.push_back(encImm(OP_LD, 3'd1, 3'd3, 3));       // Same address right after
        prog.push_back(encAdd(3'd4, 3'd3, 3'd2));
        prog.push_back(encImm(OP_ST, 3'd1, 3'd4, 4));
        prog.push_back(encImm(OP_LD, 3'd1, 3'd5, 4));
        prog.push_back(encImm(OP_LD, 3'd1, 3'd6, 5));       // Never stored, reads fill
        prog.push_back(encImm(OP_ADDI, 3'd2, 3'd2, 1));
        prog.push_back(encJump(OP_HALT, 0));
        runTest("storeLoad");
    endtask

    task automatic testJumps();
        prog.delete();
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd1, 1));
        prog.push_back(encJump(OP_J, 1));
        prog.push_back(encImm(OP_ADDI, 3'd1, 3'd1, 8));     // Skipped
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd2, 3));
        prog.push_back(encJump(OP_JAL, 1));
        prog.push_back(encImm(OP_ADDI, 3'd2, 3'd2, 4));     // Skipped
        prog.push_back(encImm(OP_ADDI, 3'd7, 3'd3, 0));
        prog.push_back(encJump(OP_J, 2));
        prog.push_back(encJump(OP_HALT, 0));
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd4, 15));    // Skipped
        prog.push_back(encJump(OP_J, -3));                  // Back to HALT
        runTest("jumps");
    endtask

    task automatic testBranches();
        prog.delete();
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd1, 3));
        prog.push_back(encBeqz(3'd1, 2));                   // Not taken
        prog.push_back(encImm(OP_ADDI, 3'd1, 3'd1, -1));
        prog.push_back(encBeqz(3'd0, 1));                   // Taken
        prog.push_back(encImm(OP_ADDI, 3'd0, 3'd2, 11));    // Culled
        prog.push_back(encImm(OP_ADDI, 3'd1, 3'd3, 4));
        prog.push_back(encImm(OP_ADDI, 3'd4, 3'd4, 3));     // Loop body
        prog.push_back(encImm(OP_ADDI, 3'd1, 3'd1, -1));
        prog.push_back(encBeqz(3'd1, 1));
        prog.push_back(encJump(OP_J, -4));
        prog.push_back(encJump(OP_HALT, 0));
        runTest("branches");
    endtask

    task automatic testRandomAddi();
        logic [31:0] rnd;
        prog.delete();
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            prog.push_back(encImm(OP_ADDI, rnd[2:0], rnd[5:3], rnd[10:6]));
        end
        prog.push_back(encJump(OP_HALT, 0));
        runTest("randomAddi");
    endtask

    initial begin
        arstN         = 1'b0;
        runEn         = 1'b0;
        loadEn        = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        mismatchCount = 0;
        failCount     = 0;
        seed          = 63;
        testAluChain();
        testStoreLoad();
        testJumps();
        testBranches();
        testRandomAddi();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; #(
    parameter int AddrWidth = 8
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    runEn,
    input  logic    loadEn,
    input  addr_t   loadAddr,
    input  word_t   loadData,
    output logic    retireValid,
    output regIdx_t retireRd,
    output word_t   retireData,
    output logic    halted
);

    word_t instr;
    logic  instrValid;
    addr_t instrPc;
    word_t baseData;
    logic  branchTaken;
    addr_t redirectPc;
    logic  stall;
    logic  pcHold;
    logic  memWe;
    addr_t memAddr;
    word_t memWdata;
    word_t memRdata;

    memBusIf fetchBus ();
    memBusIf dataBus ();

    fetchUnit u_fetch (
        .clk        (clk),
        .arstN      (arstN),
        .bus        (fetchBus.master),
        .pcHold     (pcHold),
        .stall      (stall),
        .redirect   (branchTaken),
        .redirectPc (redirectPc),
        .instr      (instr),
        .instrValid (instrValid),
        .instrPc    (instrPc)
    );

    pipeCore u_core (
        .clk         (clk),
        .arstN       (arstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrPc     (instrPc),
        .stall       (stall),
        .bus         (dataBus.master),
        .baseData    (baseData),
        .branchTaken (branchTaken),
        .redirectPc  (redirectPc),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .halted      (halted)
    );

    hazardUnit u_hazard (
        .clk         (clk),
        .arstN       (arstN),
        .instr       (instr),
        .instrValid  (instrValid),
        .baseData    (baseData),
        .branchTaken (branchTaken),
        .stall       (stall),
        .pcHold      (pcHold)
    );

    memArbiter #(.AddrWidth(AddrWidth)) u_arb (
        .clk      (clk),
        .arstN    (arstN),
        .fetchBus (fetchBus.arbiter),
        .dataBus  (dataBus.arbiter),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .runEn    (runEn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    unifiedMem #(.AddrWidth(AddrWidth)) u_mem (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

// File: unifiedMem.sv
`timescale 1ns/100ps

module unifiedMem import cpuPkg::*; #(
    parameter int AddrWidth = 8
) (
    input  logic  clk,
    input  logic  we,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [2**AddrWidth];   // Instructions and data together

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[AddrWidth-1:0]] <= wdata;
        end
        rdata <= mem[addr[AddrWidth-1:0]];   // Old contents on a write cycle
    end

endmodule

// File: memArbiter.sv
`timescale 1ns/100ps

module memArbiter import cpuPkg::*; #(
    parameter int AddrWidth = 8
) (
    input  logic     clk,
    input  logic     arstN,
    memBusIf.arbiter fetchBus,
    memBusIf.arbiter dataBus,
    input  logic     loadEn,
    input  addr_t    loadAddr,
    input  word_t    loadData,
    input  logic     runEn,
    output logic     memWe,
    output addr_t    memAddr,
    output word_t    memWdata,
    input  word_t    memRdata
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_DATA
    } owner_e;

    localparam addr_t AddrMask = addr_t'((1 << AddrWidth) - 1);

    owner_e owner;     // Master whose read is on memRdata
    logic   loadGnt;
    addr_t  selAddr;

    // Data over fetch over the load port, fetch only while running
    assign dataBus.gnt  = dataBus.req;
    assign fetchBus.gnt = fetchBus.req && !dataBus.req && runEn;
    assign loadGnt      = loadEn && !runEn && !dataBus.req;

    always_comb begin
        memWe    = 1'b0;
        selAddr  = fetchBus.addr;
        memWdata = fetchBus.wdata;
        if (dataBus.gnt) begin
            memWe    = dataBus.we;
            selAddr  = dataBus.addr;
            memWdata = dataBus.wdata;
        end else if (loadGnt) begin
            memWe    = 1'b1;
            selAddr  = loadAddr;
            memWdata = loadData;
        end
    end

    assign memAddr = selAddr & AddrMask;

    assign dataBus.rdata  = (owner == OWN_DATA)  ? memRdata : '0;
    assign fetchBus.rdata = (owner == OWN_FETCH) ? memRdata : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            owner <= OWN_NONE;
        end else if (dataBus.gnt && !dataBus.we) begin
            owner <= OWN_DATA;
        end else if (fetchBus.gnt) begin
            owner <= OWN_FETCH;
        end else begin
            owner <= OWN_NONE;
        end
    end

    oneGrant: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({dataBus.gnt, fetchBus.gnt, loadGnt}));

endmodule

// File: pipeCore.sv
`timescale 1ns/100ps

module pipeCore import cpuPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  word_t   instr,
    input  logic    instrValid,
    input  addr_t   instrPc,
    input  logic    stall,
    memBusIf.master bus,
    output word_t   baseData,
    output logic    branchTaken,
    output addr_t   redirectPc,
    output logic    retireValid,
    output regIdx_t retireRd,
    output word_t   retireData,
    output logic    halted
);

    word_t   regFile [8];
    opcode_e decOp;
    logic    issue;
    logic    haltIssued;
    logic    decWe;
    logic    decLd;
    logic    decSt;
    regIdx_t decRd;
    word_t   decImm;

    logic    exValid, exWe, exLd, exSt, exAdd, exJal, exBeqz, exHalt;
    regIdx_t exRd;
    word_t   exA;
    word_t   exB;
    word_t   exImm;
    addr_t   exPc;
    word_t   exResult;
    word_t   brSum;

    logic    memValid, memWe, memLd, memSt, memHalt;
    regIdx_t memRd;
    word_t   memResult;
    word_t   memStData;

    logic    wbValid, wbWe, wbLd, wbHalt;
    logic    haltedR;
    regIdx_t wbRd;
    word_t   wbResult;

    // Decode
    assign baseData = regFile[rsOf(instr)];
    assign issue    = instrValid && !stall && !branchTaken && !haltIssued;

    always_comb begin
        decOp  = opOf(instr);
        decWe  = 1'b0;
        decLd  = 1'b0;
        decSt  = 1'b0;
        decRd  = rtOf(instr);
        decImm = isBeqz(instr) ? imm8Of(instr) : imm5Of(instr);
        case (decOp)
            OP_JAL: begin
                decWe = 1'b1;
                decRd = LINK_REG;
            end
            OP_ADDI: decWe = 1'b1;
            OP_LD: begin
                decWe = 1'b1;
                decLd = 1'b1;
            end
            OP_ST: decSt = 1'b1;
            OP_ADD: begin
                decWe = 1'b1;
                decRd = rdOf(instr);
            end
            default: ;
        endcase
    end

    // Execute
    always_comb begin
        if (exAdd) begin
            exResult = exA + exB;
        end else if (exJal) begin
            exResult = {8'h00, exPc} + 16'd1;   // Return address
        end else begin
            exResult = exA + exImm;             // ADDI value or LD/ST address
        end
    end

    assign branchTaken = exValid && exBeqz && exA == '0;
    assign brSum       = {8'h00, exPc} + 16'd1 + exImm;
    assign redirectPc  = brSum[7:0];

    // Memory
    assign bus.req   = memValid && (memLd || memSt);
    assign bus.we    = memSt;
    assign bus.addr  = memResult[7:0];
    assign bus.wdata = memStData;

    // Writeback, load data arrives the cycle after the request
    assign retireValid = wbValid && wbWe;
    assign retireRd    = wbRd;
    assign retireData  = wbLd ? bus.rdata : wbResult;
    assign halted      = haltedR || (wbValid && wbHalt);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltIssued <= 1'b0;
            exValid    <= 1'b0;
            memValid   <= 1'b0;
            wbValid    <= 1'b0;
            haltedR    <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (issue && decOp == OP_HALT) begin
                haltIssued <= 1'b1;   // Nothing younger issues after HALT
            end
            exValid  <= issue;
            memValid <= exValid;
            wbValid  <= memValid;
            if (wbValid && wbHalt) begin
                haltedR <= 1'b1;
            end
            if (retireValid) begin
                regFile[wbRd] <= retireData;
            end
        end
    end

    always_ff @(posedge clk) begin
        exWe      <= decWe;
        exLd      <= decLd;
        exSt      <= decSt;
        exAdd     <= decOp == OP_ADD;
        exJal     <= decOp == OP_JAL;
        exBeqz    <= isBeqz(instr);
        exHalt    <= decOp == OP_HALT;
        exRd      <= decRd;
        exA       <= baseData;
        exB       <= regFile[rtOf(instr)];
        exImm     <= decImm;
        exPc      <= instrPc;
        memWe     <= exWe;
        memLd     <= exLd;
        memSt     <= exSt;
        memHalt   <= exHalt;
        memRd     <= exRd;
        memResult <= exResult;
        memStData <= exB;
        wbWe      <= memWe;
        wbLd      <= memLd;
        wbHalt    <= memHalt;
        wbRd      <= memRd;
        wbResult  <= memResult;
    end

    // The arbiter gives the data master the port without waiting
    dataAlwaysGranted: assert property (@(posedge clk) disable iff (!arstN)
        bus.req |-> bus.gnt);

endmodule

// File: fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    memBusIf.master bus,
    input  logic    pcHold,
    input  logic    stall,
    input  logic    redirect,
    input  addr_t   redirectPc,
    output word_t   instr,
    output logic    instrValid,
    output addr_t   instrPc
);

    addr_t pc;
    logic  fresh;       // Decode word is on the bus this cycle
    word_t heldInstr;
    word_t jumpSum;
    addr_t jumpTarget;
    logic  fetchGo;

    assign instr = fresh ? bus.rdata : heldInstr;

    // J and JAL targets are relative to the following word
    assign jumpSum    = {8'h00, instrPc} + 16'd1 + imm11Of(instr);
    assign jumpTarget = jumpSum[7:0];

    // Only fetch when decode will have room next cycle
    assign bus.req   = !redirect && !pcHold && (!instrValid || !stall);
    assign bus.we    = 1'b0;
    assign bus.addr  = pc;
    assign bus.wdata = '0;
    assign fetchGo   = bus.req && bus.gnt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            fresh      <= 1'b0;
            instrValid <= 1'b0;
            instrPc    <= '0;
        end else if (redirect) begin
            pc         <= redirectPc;   // Taken branch, drop the word in decode
            fresh      <= 1'b0;
            instrValid <= 1'b0;
        end else if (pcHold) begin
            pc         <= jumpTarget;   // Jump moves on, one bubble behind it
            fresh      <= 1'b0;
            instrValid <= 1'b0;
        end else if (fetchGo) begin
            pc         <= pc + addr_t'(1);
            fresh      <= 1'b1;
            instrValid <= 1'b1;
            instrPc    <= pc;
        end else begin
            fresh <= 1'b0;
            if (!stall) begin
                instrValid <= 1'b0;   // Consumed with nothing new behind it
            end
        end
    end

    always_ff @(posedge clk) begin
        heldInstr <= instr;
    end

endmodule

// File: hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit import cpuPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  word_t instr,
    input  logic  instrValid,
    input  word_t baseData,
    input  logic  branchTaken,
    output logic  stall,
    output logic  pcHold
);

    localparam int Stages = 3;   // Execute, memory, writeback

    opcode_e op;
    logic    readsRs;
    logic    readsRt;
    logic    writesReg;
    logic    memAccess;
    logic    isJump;
    regIdx_t destIdx;
    word_t   addrSum;
    addr_t   decAddr;
    logic    regHaz;
    logic    memHaz;
    logic    issue;
    logic    prevJump;

    // Entry 0 is the instruction now in execute
    regIdx_t dstQ  [Stages];
    logic    wvQ   [Stages];
    logic    memQ  [Stages];
    addr_t   addrQ [Stages];

    always_comb begin
        op        = opOf(instr);
        readsRs   = isBeqz(instr);
        readsRt   = 1'b0;
        writesReg = 1'b0;
        memAccess = 1'b0;
        isJump    = 1'b0;
        destIdx   = rtOf(instr);
        case (op)
            OP_J: isJump = 1'b1;
            OP_JAL: begin
                isJump    = 1'b1;
                writesReg = 1'b1;
                destIdx   = LINK_REG;
            end
            OP_ADDI: begin
                readsRs   = 1'b1;
                writesReg = 1'b1;
            end
            OP_ST: begin
                readsRs   = 1'b1;
                readsRt   = 1'b1;   // Store data register
                memAccess = 1'b1;
            end
            OP_LD: begin
                readsRs   = 1'b1;
                writesReg = 1'b1;
                memAccess = 1'b1;
            end
            OP_ADD: begin
                readsRs   = 1'b1;
                readsRt   = 1'b1;
                writesReg = 1'b1;
                destIdx   = rdOf(instr);
            end
            default: ;
        endcase
    end

    assign addrSum = baseData + imm5Of(instr);
    assign decAddr = addrSum[7:0];

    // Compare decode sources and address against everything in flight
    always_comb begin
        regHaz = 1'b0;
        memHaz = 1'b0;
        for (int i = 0; i < Stages; i++) begin
            if (wvQ[i] && readsRs && dstQ[i] == rsOf(instr)) begin
                regHaz = 1'b1;
            end
            if (wvQ[i] && readsRt && dstQ[i] == rtOf(instr)) begin
                regHaz = 1'b1;
            end
            if (memQ[i] && memAccess && addrQ[i] == decAddr) begin
                memHaz = 1'b1;
            end
        end
    end

    assign stall  = instrValid && (regHaz || memHaz) && !branchTaken;
    assign pcHold = instrValid && isJump && !prevJump && !branchTaken;
    assign issue  = instrValid && !stall && !branchTaken;   // Culled on a taken branch

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Stages; i++) begin
                dstQ[i] <= '0;
                wvQ[i]  <= 1'b0;
                memQ[i] <= 1'b0;
            end
            prevJump <= 1'b0;
        end else begin
            dstQ[0] <= destIdx;
            wvQ[0]  <= issue && writesReg;
            memQ[0] <= issue && memAccess;
            for (int i = 1; i < Stages; i++) begin
                dstQ[i] <= dstQ[i-1];
                wvQ[i]  <= wvQ[i-1];
                memQ[i] <= memQ[i-1];
            end
            prevJump <= pcHold;
        end
    end

    always_ff @(posedge clk) begin
        addrQ[0] <= decAddr;
        for (int i = 1; i < Stages; i++) begin
            addrQ[i] <= addrQ[i-1];
        end
    end

    // Branch resolution in execute must win over a decode stall
    stallNotOnBranch: assert property (@(posedge clk) disable iff (!arstN)
        branchTaken |-> !stall);

endmodule

// File: memBusIf.sv
`timescale 1ns/100ps

interface memBusIf import cpuPkg::*; ();

    logic  req;     // Access wanted this cycle
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;   // Valid the cycle after a granted read
    logic  gnt;     // Same-cycle level from the arbiter

    modport master (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

// File: cpuPkg.sv
package cpuPkg;

    typedef logic [15:0] word_t;   // Data and instruction word
    typedef logic [7:0]  addr_t;   // Word address, upper PC bits dropped
    typedef logic [2:0]  regIdx_t;

    // BEQZ only decodes its top three bits
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_JAL  = 5'b00110,
        OP_BEQZ = 5'b01100,
        OP_ADDI = 5'b01000,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_ADD  = 5'b11011
    } opcode_e;

    localparam regIdx_t LINK_REG = 3'd7;   // JAL return address

    function automatic opcode_e opOf(input word_t instr);
        return opcode_e'(instr[15:11]);
    endfunction

    function automatic logic isBeqz(input word_t instr);
        return instr[15:13] == OP_BEQZ[4:2];
    endfunction

    function automatic regIdx_t rsOf(input word_t instr);
        return instr[10:8];
    endfunction

    function automatic regIdx_t rtOf(input word_t instr);
        return instr[7:5];
    endfunction

    function automatic regIdx_t rdOf(input word_t instr);
        return instr[4:2];
    endfunction

    // Sign-extended immediates
    function automatic word_t imm5Of(input word_t instr);
        return {{11{instr[4]}}, instr[4:0]};
    endfunction

    function automatic word_t imm8Of(input word_t instr);
        return {{8{instr[7]}}, instr[7:0]};
    endfunction

    function automatic word_t imm11Of(input word_t instr);
        return {{5{instr[10]}}, instr[10:0]};
    endfunction

endpackage
